// File: common/mem_sys_pkg.sv
package mem_sys_pkg;

    // Line and burst geometry
    localparam int LINE_BITS       = 256;
    localparam int BURST_BITS      = 64;
    localparam int BURSTS_PER_LINE = LINE_BITS / BURST_BITS;

    // Field view for the default 8-set cache
    typedef struct packed {
        logic [23:0] tag;
        logic [2:0]  set;
        logic [2:0]  word;
        logic [1:0]  byte_off;
    } addr_fields_t;

    // One address word, seen raw or split into cache fields
    typedef union packed {
        logic [31:0]  raw;
        addr_fields_t f;
    } mem_addr_u;

    // Owner of the shared line port
    typedef enum logic [1:0] {
        GRANT_IDLE   = 2'd0,
        GRANT_ICACHE = 2'd1,
        GRANT_DCACHE = 2'd2
    } grant_e;

endpackage

// File: cache/line_cache.sv
`timescale 1ns/1ps

module line_cache #(
    parameter int NUM_SETS = 8
) (
    input  logic                           clk,
    input  logic                           rst_n_i,

    // Client side
    input  logic                           cpu_read_i,
    input  logic                           cpu_write_i,
    input  logic [31:0]                    cpu_addr_i,
    input  logic [31:0]                    cpu_wdata_i,
    input  logic [3:0]                     cpu_be_i,
    output logic [31:0]                    cpu_rdata_o,
    output logic                           cpu_resp_o,
    output logic                           cpu_hit_o,

    // Line side
    output logic                           line_read_o,
    output logic                           line_write_o,
    output logic [31:0]                    line_addr_o,
    output logic [mem_sys_pkg::LINE_BITS-1:0] line_wdata_o,
    input  logic [mem_sys_pkg::LINE_BITS-1:0] line_rdata_i,
    input  logic                           line_resp_i
);

    import mem_sys_pkg::*;

    localparam int IDX_BITS = $clog2(NUM_SETS);
    localparam int TAG_W    = 32 - IDX_BITS - 5;

    localparam logic [1:0] ST_IDLE      = 2'd0;
    localparam logic [1:0] ST_WRITEBACK = 2'd1;
    localparam logic [1:0] ST_FILL      = 2'd2;

    // Storage arrays
    logic [TAG_W-1:0]     tag_q  [NUM_SETS];
    logic [LINE_BITS-1:0] data_q [NUM_SETS];
    logic [NUM_SETS-1:0]  valid_q;
    logic [NUM_SETS-1:0]  dirty_q;

    logic [1:0]           state;
    logic                 missed;

    mem_addr_u            cpu_addr;
    logic [IDX_BITS-1:0]  idx;
    logic [TAG_W-1:0]     tag;

    logic                 req;
    logic                 hit;
    logic                 hit_access;
    logic                 fill_done;
    logic [LINE_BITS-1:0] cur_line;
    logic [31:0]          cur_word;
    logic [LINE_BITS-1:0] merged_line;

    assign cpu_addr.raw = cpu_addr_i;

    // Default geometry matches the package field view
    generate
        if (NUM_SETS == 8) begin : g_field_decode
            assign idx = cpu_addr.f.set;
            assign tag = cpu_addr.f.tag;
        end else begin : g_raw_decode
            assign idx = cpu_addr.raw[5 +: IDX_BITS];
            assign tag = cpu_addr.raw[31 -: TAG_W];
        end
    endgenerate

    // The request is still held during its resp cycle, so skip it then
    assign req = (cpu_read_i || cpu_write_i) && !cpu_resp_o;

    assign hit        = valid_q[idx] && (tag_q[idx] == tag);
    assign hit_access = (state == ST_IDLE) && req && hit;
    assign fill_done  = (state == ST_FILL) && line_resp_i;

    assign cur_line = data_q[idx];
    assign cur_word = cur_line[cpu_addr.f.word * 32 +: 32];

    // Byte merge of a store into the addressed word
    always_comb begin
        merged_line = cur_line;
        for (int b = 0; b < 4; b++) begin
            if (cpu_be_i[b]) begin
                merged_line[cpu_addr.f.word * 32 + b * 8 +: 8] = cpu_wdata_i[b * 8 +: 8];
            end
        end
    end

    // Control state and line flags
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state      <= ST_IDLE;
            missed     <= 1'b0;
            valid_q    <= '0;
            dirty_q    <= '0;
            cpu_resp_o <= 1'b0;
            cpu_hit_o  <= 1'b0;
        end else begin
            cpu_resp_o <= 1'b0;
            cpu_hit_o  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        if (hit) begin
                            cpu_resp_o <= 1'b1;
                            cpu_hit_o  <= !missed;
                            missed     <= 1'b0;
                            if (cpu_write_i) begin
                                dirty_q[idx] <= 1'b1;
                            end
                        end else begin
                            missed <= 1'b1;
                            // Dirty victim goes out before the refill
                            if (valid_q[idx] && dirty_q[idx]) begin
                                state <= ST_WRITEBACK;
                            end else begin
                                state <= ST_FILL;
                            end
                        end
                    end
                end
                ST_WRITEBACK: begin
                    if (line_resp_i) begin
                        state <= ST_FILL;
                    end
                end
                ST_FILL: begin
                    if (line_resp_i) begin
                        valid_q[idx] <= 1'b1;
                        dirty_q[idx] <= 1'b0;
                        state        <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Arrays and read data
    always_ff @(posedge clk) begin
        if (hit_access) begin
            cpu_rdata_o <= cur_word;
            if (cpu_write_i) begin
                data_q[idx] <= merged_line;
            end
        end
        if (fill_done) begin
            data_q[idx] <= line_rdata_i;
            tag_q[idx]  <= tag;
        end
    end

    assign line_read_o  = (state == ST_FILL);
    assign line_write_o = (state == ST_WRITEBACK);

    // Victim address uses the stored tag
    assign line_addr_o  = (state == ST_WRITEBACK) ? {tag_q[idx], idx, 5'b0}
                                                  : {tag, idx, 5'b0};
    assign line_wdata_o = cur_line;

endmodule

// File: hdl/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                              clk,
    input  logic                              rst_n_i,

    // Instruction cache
    input  logic                              icache_read_i,
    input  logic [31:0]                       icache_addr_i,
    output logic [mem_sys_pkg::LINE_BITS-1:0] icache_rdata_o,
    output logic                              icache_resp_o,

    // Data cache
    input  logic                              dcache_read_i,
    input  logic                              dcache_write_i,
    input  logic [31:0]                       dcache_addr_i,
    input  logic [mem_sys_pkg::LINE_BITS-1:0] dcache_wdata_i,
    output logic [mem_sys_pkg::LINE_BITS-1:0] dcache_rdata_o,
    output logic                              dcache_resp_o,

    // Adaptor side
    output logic                              arb_read_o,
    output logic                              arb_write_o,
    output logic [31:0]                       arb_addr_o,
    output logic [mem_sys_pkg::LINE_BITS-1:0] arb_wdata_o,
    input  logic [mem_sys_pkg::LINE_BITS-1:0] arb_rdata_i,
    input  logic                              arb_resp_i
);

    import mem_sys_pkg::*;

    grant_e owner;
    grant_e sel;

    // New grant only when idle, data cache first
    always_comb begin
        sel = owner;
        if (owner == GRANT_IDLE) begin
            if (dcache_read_i || dcache_write_i) begin
                sel = GRANT_DCACHE;
            end else if (icache_read_i) begin
                sel = GRANT_ICACHE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            owner <= GRANT_IDLE;
        end else if (arb_resp_i) begin
            owner <= GRANT_IDLE;
        end else begin
            owner <= sel;
        end
    end

    assign arb_read_o  = ((sel == GRANT_DCACHE) && dcache_read_i) ||
                         ((sel == GRANT_ICACHE) && icache_read_i);
    assign arb_write_o = (sel == GRANT_DCACHE) && dcache_write_i;
    assign arb_addr_o  = (sel == GRANT_DCACHE) ? dcache_addr_i : icache_addr_i;
    // Only the data cache ever writes a line
    assign arb_wdata_o = dcache_wdata_i;

    assign icache_rdata_o = arb_rdata_i;
    assign dcache_rdata_o = arb_rdata_i;
    assign icache_resp_o  = arb_resp_i && (owner == GRANT_ICACHE);
    assign dcache_resp_o  = arb_resp_i && (owner == GRANT_DCACHE);

endmodule

// File: hdl/line_adaptor.sv
`timescale 1ns/1ps

module line_adaptor (
    input  logic                               clk,
    input  logic                               rst_n_i,

    // Line port
    input  logic                               line_read_i,
    input  logic                               line_write_i,
    input  logic [31:0]                        line_addr_i,
    input  logic [mem_sys_pkg::LINE_BITS-1:0]  line_wdata_i,
    output logic [mem_sys_pkg::LINE_BITS-1:0]  line_rdata_o,
    output logic                               line_resp_o,

    // Burst memory port
    output logic                               mem_read_o,
    output logic                               mem_write_o,
    output logic [31:0]                        mem_addr_o,
    output logic [mem_sys_pkg::BURST_BITS-1:0] mem_wdata_o,
    input  logic [mem_sys_pkg::BURST_BITS-1:0] mem_rdata_i,
    input  logic                               mem_resp_i
);

    import mem_sys_pkg::*;

    localparam int CNT_BITS = $clog2(BURSTS_PER_LINE);

    localparam logic [1:0] AD_IDLE  = 2'd0;
    localparam logic [1:0] AD_BURST = 2'd1;
    localparam logic [1:0] AD_DONE  = 2'd2;

    logic [1:0]           state;
    logic [CNT_BITS-1:0]  cnt;
    logic [LINE_BITS-1:0] line_q;
    logic                 start;
    logic                 last_burst;

    assign start      = (state == AD_IDLE) && (line_read_i || line_write_i);
    assign last_burst = (state == AD_BURST) && mem_resp_i &&
                        (cnt == CNT_BITS'(BURSTS_PER_LINE - 1));

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state       <= AD_IDLE;
            cnt         <= '0;
            mem_read_o  <= 1'b0;
            mem_write_o <= 1'b0;
            line_resp_o <= 1'b0;
        end else begin
            case (state)
                AD_IDLE: begin
                    if (start) begin
                        mem_write_o <= line_write_i;
                        mem_read_o  <= line_read_i;
                        cnt         <= '0;
                        state       <= AD_BURST;
                    end
                end
                AD_BURST: begin
                    if (mem_resp_i) begin
                        cnt <= cnt + 1'b1;
                    end
                    if (last_burst) begin
                        mem_read_o  <= 1'b0;
                        mem_write_o <= 1'b0;
                        line_resp_o <= 1'b1;
                        state       <= AD_DONE;
                    end
                end
                // Upstream request drops during this resp cycle
                AD_DONE: begin
                    line_resp_o <= 1'b0;
                    state       <= AD_IDLE;
                end
                default: begin
                    state <= AD_IDLE;
                end
            endcase
        end
    end

    // Line buffer serves both directions
    always_ff @(posedge clk) begin
        if (start) begin
            mem_addr_o <= line_addr_i;
            line_q     <= line_wdata_i;
        end else if ((state == AD_BURST) && mem_resp_i && mem_read_o) begin
            line_q[cnt * BURST_BITS +: BURST_BITS] <= mem_rdata_i;
        end
    end

    assign mem_wdata_o  = line_q[cnt * BURST_BITS +: BURST_BITS];
    assign line_rdata_o = line_q;

endmodule

// File: hdl/mem_sys_top.sv
`timescale 1ns/1ps

module mem_sys_top #(
    parameter int NUM_SETS = 8
) (
    input  logic                               clk,
    input  logic                               rst_n_i,

    // Instruction port
    input  logic                               inst_read_i,
    input  logic [31:0]                        inst_addr_i,
    output logic [31:0]                        inst_rdata_o,
    output logic                               inst_resp_o,
    output logic                               inst_hit_o,

    // Data port
    input  logic                               data_read_i,
    input  logic                               data_write_i,
    input  logic [31:0]                        data_addr_i,
    input  logic [31:0]                        data_wdata_i,
    input  logic [3:0]                         data_be_i,
    output logic [31:0]                        data_rdata_o,
    output logic                               data_resp_o,
    output logic                               data_hit_o,

    // External memory
    output logic                               mem_read_o,
    output logic                               mem_write_o,
    output logic [31:0]                        mem_addr_o,
    output logic [mem_sys_pkg::BURST_BITS-1:0] mem_wdata_o,
    input  logic [mem_sys_pkg::BURST_BITS-1:0] mem_rdata_i,
    input  logic                               mem_resp_i
);

    import mem_sys_pkg::*;

    logic                 icache_line_read;
    logic [31:0]          icache_line_addr;
    logic [LINE_BITS-1:0] icache_line_rdata;
    logic                 icache_line_resp;

    logic                 dcache_line_read;
    logic                 dcache_line_write;
    logic [31:0]          dcache_line_addr;
    logic [LINE_BITS-1:0] dcache_line_wdata;
    logic [LINE_BITS-1:0] dcache_line_rdata;
    logic                 dcache_line_resp;

    logic                 arb_read;
    logic                 arb_write;
    logic [31:0]          arb_addr;
    logic [LINE_BITS-1:0] arb_wdata;
    logic [LINE_BITS-1:0] arb_rdata;
    logic                 arb_resp;

    // Read-only cache, never dirty, so its write side stays open
    line_cache #(.NUM_SETS(NUM_SETS)) icache (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .cpu_read_i   (inst_read_i),
        .cpu_write_i  (1'b0),
        .cpu_addr_i   (inst_addr_i),
        .cpu_wdata_i  (32'd0),
        .cpu_be_i     (4'hf),
        .cpu_rdata_o  (inst_rdata_o),
        .cpu_resp_o   (inst_resp_o),
        .cpu_hit_o    (inst_hit_o),
        .line_read_o  (icache_line_read),
        .line_write_o (),
        .line_addr_o  (icache_line_addr),
        .line_wdata_o (),
        .line_rdata_i (icache_line_rdata),
        .line_resp_i  (icache_line_resp)
    );

    line_cache #(.NUM_SETS(NUM_SETS)) dcache (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .cpu_read_i   (data_read_i),
        .cpu_write_i  (data_write_i),
        .cpu_addr_i   (data_addr_i),
        .cpu_wdata_i  (data_wdata_i),
        .cpu_be_i     (data_be_i),
        .cpu_rdata_o  (data_rdata_o),
        .cpu_resp_o   (data_resp_o),
        .cpu_hit_o    (data_hit_o),
        .line_read_o  (dcache_line_read),
        .line_write_o (dcache_line_write),
        .line_addr_o  (dcache_line_addr),
        .line_wdata_o (dcache_line_wdata),
        .line_rdata_i (dcache_line_rdata),
        .line_resp_i  (dcache_line_resp)
    );

    mem_arbiter arbiter (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .icache_read_i  (icache_line_read),
        .icache_addr_i  (icache_line_addr),
        .icache_rdata_o (icache_line_rdata),
        .icache_resp_o  (icache_line_resp),
        .dcache_read_i  (dcache_line_read),
        .dcache_write_i (dcache_line_write),
        .dcache_addr_i  (dcache_line_addr),
        .dcache_wdata_i (dcache_line_wdata),
        .dcache_rdata_o (dcache_line_rdata),
        .dcache_resp_o  (dcache_line_resp),
        .arb_read_o     (arb_read),
        .arb_write_o    (arb_write),
        .arb_addr_o     (arb_addr),
        .arb_wdata_o    (arb_wdata),
        .arb_rdata_i    (arb_rdata),
        .arb_resp_i     (arb_resp)
    );

    line_adaptor adaptor (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .line_read_i  (arb_read),
        .line_write_i (arb_write),
        .line_addr_i  (arb_addr),
        .line_wdata_i (arb_wdata),
        .line_rdata_o (arb_rdata),
        .line_resp_o  (arb_resp),
        .mem_read_o   (mem_read_o),
        .mem_write_o  (mem_write_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_rdata_i  (mem_rdata_i),
        .mem_resp_i   (mem_resp_i)
    );

endmodule

// File: tb/mem_sys_checker.sv
`timescale 1ns/1ps

module mem_sys_checker #(
    parameter bit CHECK_GRANT = 1'b1
) (
    input logic                clk,
    input logic                rst_n_i,
    input mem_sys_pkg::grant_e owner_i,
    input logic                resp_i,
    input logic                rd_i,
    input logic                wr_i
);

    import mem_sys_pkg::*;

    int fail_count = 0;

    resp_one_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
        resp_i |=> !resp_i)
        else begin
            fail_count++;
            $error("response stayed high for more than one cycle");
        end

    // Owner may only fall back to idle through a response
    if (CHECK_GRANT) begin : g_grant
        grant_held: assert property (@(posedge clk) disable iff (!rst_n_i)
            (owner_i != GRANT_IDLE && !resp_i) |=> (owner_i == $past(owner_i)))
            else begin
                fail_count++;
                $error("grant changed during an active transfer");
            end
    end

    rd_wr_exclusive: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(rd_i && wr_i))
        else begin
            fail_count++;
            $error("read and write requested together");
        end

endmodule

bind mem_arbiter mem_sys_checker arb_checks (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .owner_i (owner),
    .resp_i  (arb_resp_i),
    .rd_i    (arb_read_o),
    .wr_i    (arb_write_o)
);

// No owner on the burst side
bind line_adaptor mem_sys_checker #(.CHECK_GRANT(1'b0)) burst_checks (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .owner_i (mem_sys_pkg::GRANT_IDLE),
    .resp_i  (line_resp_o),
    .rd_i    (mem_read_o),
    .wr_i    (mem_write_o)
);

// File: tb/mem_sys_monitor.sv
`timescale 1ns/1ps

module mem_sys_monitor (
    input logic                               clk,
    input logic                               rst_n_i,
    input logic                               inst_read_i,
    input logic [31:0]                        inst_addr_i,
    input logic [31:0]                        inst_rdata_i,
    input logic                               inst_resp_i,
    input logic                               inst_hit_i,
    input logic                               data_read_i,
    input logic                               data_write_i,
    input logic [31:0]                        data_addr_i,
    input logic [31:0]                        data_wdata_i,
    input logic [3:0]                         data_be_i,
    input logic [31:0]                        data_rdata_i,
    input logic                               data_resp_i,
    input logic                               data_hit_i,
    input logic                               mem_read_i,
    input logic                               mem_write_i,
    input logic [31:0]                        mem_addr_i,
    input logic [mem_sys_pkg::BURST_BITS-1:0] mem_wdata_i,
    input logic                               mem_resp_i
);

    // Byte image of memory as the clients should see it
    logic [7:0]  ref_mem [4096];
    // Per set {valid, tag}
    logic [24:0] inst_tags [8];
    logic [24:0] data_tags [8];

    logic        inst_pend;
    logic        data_pend;
    logic [31:0] inst_addr_q;
    logic [31:0] data_addr_q;
    logic [31:0] data_wdata_q;
    logic [3:0]  data_be_q;
    logic        data_write_q;
    logic        started;
    logic [1:0]  beat;

    int error_count  = 0;
    int read_checks  = 0;
    int hit_checks   = 0;
    int burst_checks = 0;
    int inst_done    = 0;
    int data_done    = 0;

    function automatic logic [7:0] preload_byte(input logic [11:0] a);
        return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h96;
    endfunction

    function automatic logic [63:0] ref_bytes(input logic [11:0] a, input int n);
        logic [63:0] w;
        w = '0;
        for (int k = 0; k < n; k++) begin
            w[k * 8 +: 8] = ref_mem[a + 12'(k)];
        end
        return w;
    endfunction

    task automatic report_value(input string test, input logic [63:0] exp,
                                input logic [63:0] act);
        $display("FAIL %s expected %0h actual %0h", test, exp, act);
        error_count++;
    endtask

    task automatic check_fetch();
        logic [63:0] exp;
        logic        exp_hit;
        exp = '0;
        for (int k = 0; k < 4; k++) begin
            exp[k * 8 +: 8] = preload_byte(inst_addr_q[11:0] + 12'(k));
        end
        exp_hit = (inst_tags[inst_addr_q[7:5]] == {1'b1, inst_addr_q[31:8]});
        if ({32'd0, inst_rdata_i} !== exp) begin
            report_value("inst_read", exp, {32'd0, inst_rdata_i});
        end
        if (inst_hit_i !== exp_hit) begin
            report_value("inst_hit", {63'd0, exp_hit}, {63'd0, inst_hit_i});
        end
        inst_tags[inst_addr_q[7:5]] = {1'b1, inst_addr_q[31:8]};
        read_checks++;
        hit_checks++;
        inst_done++;
    endtask

    task automatic check_data_access();
        logic [63:0] exp;
        logic        exp_hit;
        exp     = ref_bytes(data_addr_q[11:0], 4);
        exp_hit = (data_tags[data_addr_q[7:5]] == {1'b1, data_addr_q[31:8]});
        if (data_hit_i !== exp_hit) begin
            report_value("data_hit", {63'd0, exp_hit}, {63'd0, data_hit_i});
        end
        if (data_write_q) begin
            // Only enabled bytes change
            for (int b = 0; b < 4; b++) begin
                if (data_be_q[b]) begin
                    ref_mem[data_addr_q[11:0] + 12'(b)] = data_wdata_q[b * 8 +: 8];
                end
            end
        end else begin
            if ({32'd0, data_rdata_i} !== exp) begin
                report_value("data_read", exp, {32'd0, data_rdata_i});
            end
            read_checks++;
        end
        data_tags[data_addr_q[7:5]] = {1'b1, data_addr_q[31:8]};
        hit_checks++;
        data_done++;
    endtask

    task automatic check_write_burst();
        logic [63:0] exp;
        if (!(mem_read_i || mem_write_i)) begin
            beat = 2'd0;
        end else if (mem_resp_i) begin
            if (mem_write_i) begin
                exp = ref_bytes({mem_addr_i[11:5], beat, 3'b000}, 8);
                if (mem_wdata_i !== exp) begin
                    report_value("write_burst", exp, mem_wdata_i);
                end
                burst_checks++;
            end
            beat = beat + 2'd1;
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n_i) begin
            inst_pend = 1'b0;
            data_pend = 1'b0;
            started   = 1'b0;
            beat      = 2'd0;
            for (int a = 0; a < 4096; a++) begin
                ref_mem[a] = preload_byte(12'(a));
            end
            for (int s = 0; s < 8; s++) begin
                inst_tags[s] = '0;
                data_tags[s] = '0;
            end
        end else begin
            // Quiet outputs until the first request
            if (!started && (inst_resp_i || data_resp_i || mem_read_i || mem_write_i)) begin
                report_value("reset_idle", 64'd0,
                             {60'd0, inst_resp_i, data_resp_i, mem_read_i, mem_write_i});
            end
            if (inst_resp_i) begin
                if (inst_pend) begin
                    check_fetch();
                    inst_pend = 1'b0;
                end else begin
                    $display("Instruction port responded without a pending request");
                    error_count++;
                end
            end
            if (data_resp_i) begin
                if (data_pend) begin
                    check_data_access();
                    data_pend = 1'b0;
                end else begin
                    $display("Data port responded without a pending request");
                    error_count++;
                end
            end
            if (!inst_pend && inst_read_i) begin
                inst_addr_q = inst_addr_i;
                inst_pend   = 1'b1;
            end
            if (!data_pend && (data_read_i || data_write_i)) begin
                data_addr_q  = data_addr_i;
                data_wdata_q = data_wdata_i;
                data_be_q    = data_be_i;
                data_write_q = data_write_i;
                data_pend    = 1'b1;
            end
            if (inst_read_i || data_read_i || data_write_i) begin
                started = 1'b1;
            end
            check_write_burst();
        end
    end

endmodule

// File: tb/mem_sys_tb.sv
`timescale 1ns/1ps

module mem_sys_tb;

    import mem_sys_pkg::*;

    localparam int NUM_REQS       = 200;
    // About 30 cycles per transaction, plus two thirds margin
    localparam int WORST_CYCLES   = 30;
    localparam int TIMEOUT_CYCLES = (2 * NUM_REQS * WORST_CYCLES * 5) / 3;
    localparam int MEM_WORDS      = 4096 / (BURST_BITS / 8);

    logic                  clk;
    logic                  rst_n;
    logic                  inst_read;
    logic [31:0]           inst_addr;
    logic [31:0]           inst_rdata;
    logic                  inst_resp;
    logic                  inst_hit;
    logic                  data_read;
    logic                  data_write;
    logic [31:0]           data_addr;
    logic [31:0]           data_wdata;
    logic [3:0]            data_be;
    logic [31:0]           data_rdata;
    logic                  data_resp;
    logic                  data_hit;
    logic                  mem_read;
    logic                  mem_write;
    logic [31:0]           mem_addr;
    logic [BURST_BITS-1:0] mem_wdata;
    logic [BURST_BITS-1:0] mem_rdata;
    logic                  mem_resp;

    logic [BURST_BITS-1:0] mem_words [MEM_WORDS];
    integer                seed;
    int                    assert_fails;
    int                    total_errors;

    function automatic logic [BURST_BITS-1:0] preload_word(input int idx);
        logic [11:0]           a;
        logic [BURST_BITS-1:0] w;
        for (int k = 0; k < 8; k++) begin
            a = 12'(idx * 8 + k);
            w[k * 8 +: 8] = a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h96;
        end
        return w;
    endfunction

    mem_sys_top #(.NUM_SETS(8)) mem_sys_top_inst (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .inst_read_i  (inst_read),
        .inst_addr_i  (inst_addr),
        .inst_rdata_o (inst_rdata),
        .inst_resp_o  (inst_resp),
        .inst_hit_o   (inst_hit),
        .data_read_i  (data_read),
        .data_write_i (data_write),
        .data_addr_i  (data_addr),
        .data_wdata_i (data_wdata),
        .data_be_i    (data_be),
        .data_rdata_o (data_rdata),
        .data_resp_o  (data_resp),
        .data_hit_o   (data_hit),
        .mem_read_o   (mem_read),
        .mem_write_o  (mem_write),
        .mem_addr_o   (mem_addr),
        .mem_wdata_o  (mem_wdata),
        .mem_rdata_i  (mem_rdata),
        .mem_resp_i   (mem_resp)
    );

    mem_sys_monitor mem_sys_monitor_inst (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .inst_read_i  (inst_read),
        .inst_addr_i  (inst_addr),
        .inst_rdata_i (inst_rdata),
        .inst_resp_i  (inst_resp),
        .inst_hit_i   (inst_hit),
        .data_read_i  (data_read),
        .data_write_i (data_write),
        .data_addr_i  (data_addr),
        .data_wdata_i (data_wdata),
        .data_be_i    (data_be),
        .data_rdata_i (data_rdata),
        .data_resp_i  (data_resp),
        .data_hit_i   (data_hit),
        .mem_read_i   (mem_read),
        .mem_write_i  (mem_write),
        .mem_addr_i   (mem_addr),
        .mem_wdata_i  (mem_wdata),
        .mem_resp_i   (mem_resp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Tags 0 to 3 in the low 1 KB, all sets and words
    task automatic run_inst_port();
        logic [31:0] r;
        for (int n = 0; n < NUM_REQS; n++) begin
            @(negedge clk);
            r = $random(seed);
            inst_addr = {22'd0, r[9:2], 2'b00};
            inst_read = 1'b1;
            @(negedge clk);
            while (inst_resp !== 1'b1) @(negedge clk);
            inst_read = 1'b0;
            if (r[12]) @(negedge clk);
        end
    endtask

    // Tags 8 to 11, so the data region starts at 2 KB
    task automatic run_data_port();
        logic [31:0] r;
        logic [31:0] wd;
        for (int n = 0; n < NUM_REQS; n++) begin
            @(negedge clk);
            r  = $random(seed);
            wd = $random(seed);
            data_addr  = {20'd0, 2'b10, r[9:2], 2'b00};
            data_wdata = wd;
            data_be    = r[15:12];
            data_write = r[0];
            data_read  = !r[0];
            @(negedge clk);
            while (data_resp !== 1'b1) @(negedge clk);
            data_read  = 1'b0;
            data_write = 1'b0;
            if (r[16]) @(negedge clk);
        end
    endtask

    // Burst memory, one beat per resp after 0 to 3 idle cycles
    initial begin : memory_model
        int          beat;
        int          idle_left;
        logic [31:0] r;
        logic [8:0]  idx;
        mem_resp  = 1'b0;
        mem_rdata = '0;
        beat      = 0;
        idle_left = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_words[i] = preload_word(i);
        end
        forever begin
            @(negedge clk);
            mem_resp = 1'b0;
            if (rst_n !== 1'b1 || !(mem_read === 1'b1 || mem_write === 1'b1)) begin
                beat = 0;
            end else if (idle_left > 0) begin
                idle_left--;
            end else begin
                idx = mem_addr[11:3] + 9'(beat);
                if (mem_write) begin
                    mem_words[idx] = mem_wdata;
                end else begin
                    mem_rdata = mem_words[idx];
                end
                mem_resp = 1'b1;
                beat++;
                r = $random(seed);
                idle_left = {30'd0, r[1:0]};
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, a request never got its response", cycles);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        seed       = 48;
        rst_n      = 1'b0;
        inst_read  = 1'b0;
        inst_addr  = '0;
        data_read  = 1'b0;
        data_write = 1'b0;
        data_addr  = '0;
        data_wdata = '0;
        data_be    = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        // A few quiet cycles for the idle check
        repeat (3) @(negedge clk);
        fork
            run_inst_port();
            run_data_port();
        join
        repeat (4) @(negedge clk);

        assert_fails = mem_sys_top_inst.arbiter.arb_checks.fail_count +
                       mem_sys_top_inst.adaptor.burst_checks.fail_count;
        total_errors = mem_sys_monitor_inst.error_count + assert_fails;
        if (mem_sys_monitor_inst.inst_done != NUM_REQS ||
            mem_sys_monitor_inst.data_done != NUM_REQS) begin
            $display("Missing responses, %0d instruction and %0d data seen",
                     mem_sys_monitor_inst.inst_done, mem_sys_monitor_inst.data_done);
            total_errors++;
        end
        $display("Checked %0d reads, %0d hits, %0d bursts; %0d errors, %0d assertion failures",
                 mem_sys_monitor_inst.read_checks, mem_sys_monitor_inst.hit_checks,
                 mem_sys_monitor_inst.burst_checks, total_errors - assert_fails,
                 assert_fails);
        if (total_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
common/mem_sys_pkg.sv
cache/line_cache.sv
hdl/mem_arbiter.sv
hdl/line_adaptor.sv
hdl/mem_sys_top.sv
tb/mem_sys_checker.sv
tb/mem_sys_monitor.sv
tb/mem_sys_tb.sv

// File: run.sh
#!/bin/sh
# Build and run with Verilator, then look for the fail message in sim.log
rm -rf obj_dir sim.log
{ verilator --binary --timing --assert --timescale 1ns/1ps \
      --top-module mem_sys_tb -f compile.f > sim.log 2>&1 \
  && ./obj_dir/Vmem_sys_tb +verilator+error+limit+1000 >> sim.log 2>&1 ; } \
  || echo "Test FAILED" >> sim.log
cat sim.log
grep -q "Test FAILED" sim.log && exit 1 || exit 0
